//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dtw_accel
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src.f
+incdir+verilog
verilog/dtw_pkg.sv
verilog/dtw_reg_file.sv
verilog/dtw_src_fifo.sv
verilog/dtw_ref_mem.sv
verilog/dtw_ref_loader.sv
verilog/dtw_core.sv
verilog/dtw_accel.sv
test/dtw_properties.sv
test/tb_dtw_accel.sv

//--- test/dtw_properties.sv
`timescale 1ns/1ps

module dtw_properties (
    input logic S_AXI_clk,
    input logic w_axi_rst,
    input logic i_src_valid,
    input logic i_fifo_full,
    input logic i_sink_credit,
    input logic i_sink_valid,
    input logic i_ld_gnt,
    input logic i_core_gnt,
    input logic i_dbg_gnt
);
    logic [15:0] held;

    // Shadow count of sink slots the engine holds
    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            held <= '0;
        end else begin
            held <= held + {15'd0, i_sink_credit} - {15'd0, i_sink_valid};
        end
    end

    a_no_push_full: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        !(i_src_valid && i_fifo_full))
        else $error("source push while the FIFO is full");

    a_sink_credit: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        i_sink_valid |-> (held != '0))
        else $error("result emitted without a sink credit");

    a_one_grant: assert property (@(posedge S_AXI_clk) disable iff (w_axi_rst)
        $onehot0({i_ld_gnt, i_core_gnt, i_dbg_gnt}))
        else $error("more than one memory grant in a cycle");

endmodule

bind dtw_accel dtw_properties u_props (
    .S_AXI_clk(S_AXI_clk),
    .w_axi_rst(w_axi_rst),
    .i_src_valid(i_src_valid),
    .i_fifo_full(fifo_full),
    .i_sink_credit(i_sink_credit),
    .i_sink_valid(o_sink_valid),
    .i_ld_gnt(ld_gnt),
    .i_core_gnt(core_gnt),
    .i_dbg_gnt(dbg_gnt)
);

//--- test/tb_dtw_accel.sv
`timescale 1ns/1ps
`include "dtw_defs.svh"

module tb_dtw_accel import dtw_pkg::*; ();

    localparam int REF_LEN = 20;
    localparam int LIMIT   = 20000;

    logic      S_AXI_clk;
    logic      w_axi_rst;
    logic      i_reg_wr;
    logic      i_reg_rd;
    reg_addr_t i_reg_addr;
    reg_data_t i_reg_wdata;
    reg_data_t o_reg_rdata;
    logic      o_reg_ack;
    logic      o_reg_err;
    logic      i_src_valid;
    sample_t   i_src_data;
    logic      i_src_last;
    logic      o_src_credit;
    logic      o_sink_valid;
    dist_t     o_sink_data;
    logic      i_sink_credit;

    logic [31:0] lfsr = 32'd1;
    int          errors = 0;
    int          checks = 0;
    int          credits_seen = 0;
    int          sent = 0;
    int          expected_sent = 0;
    int          checked = 0;
    sample_t     ref_buf [REF_LEN];
    sample_t     query_buf [16];
    logic [16:0] tx_q [$];
    dist_t       got_q [$];
    dist_t       exp_q [$];

    dtw_accel uut (.*);

    initial begin
        S_AXI_clk = 1'b0;
        forever #10 S_AXI_clk = ~S_AXI_clk;
    end

    // Returned credits and results are taken on the edge
    always @(posedge S_AXI_clk) begin
        if (!w_axi_rst && o_src_credit) credits_seen++;
        if (!w_axi_rst && o_sink_valid) got_q.push_back(o_sink_data);
    end

    // Source sender spends one credit per sample
    initial begin
        logic [16:0] entry;
        int          avail;
        i_src_valid = 1'b0;
        i_src_data  = '0;
        i_src_last  = 1'b0;
        forever begin
            @(posedge S_AXI_clk);
            #1;
            avail = `DTW_SRC_DEPTH + credits_seen - sent;
            if (!w_axi_rst && tx_q.size() > 0 && avail > 0) begin
                entry       = tx_q.pop_front();
                i_src_valid = 1'b1;
                i_src_data  = entry[15:0];
                i_src_last  = entry[16];
                sent++;
            end else begin
                i_src_valid = 1'b0;
            end
        end
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic reg_access(input logic wr, input reg_addr_t addr, input reg_data_t data,
                              output reg_data_t rdata, output logic err);
        int cnt;
        @(posedge S_AXI_clk);
        #1;
        i_reg_wr    = wr;
        i_reg_rd    = !wr;
        i_reg_addr  = addr;
        i_reg_wdata = data;
        @(posedge S_AXI_clk);
        #1;
        i_reg_wr = 1'b0;
        i_reg_rd = 1'b0;
        cnt      = 0;
        while (!o_reg_ack && cnt < LIMIT) begin
            @(posedge S_AXI_clk);
            #1;
            cnt++;
        end
        if (!o_reg_ack) begin
            errors++;
            $display("Register access to index %0d was never acknowledged", addr);
        end
        rdata = o_reg_rdata;
        err   = o_reg_err;
    endtask

    task automatic grant_credit();
        @(posedge S_AXI_clk);
        #1;
        i_sink_credit = 1'b1;
        @(posedge S_AXI_clk);
        #1;
        i_sink_credit = 1'b0;
    endtask

    // Recurrence over one query, row by row against the stored reference
    function automatic dist_t dtw_model(input int qlen);
        dist_t prev [REF_LEN];
        dist_t cur [REF_LEN];
        dist_t c;
        dist_t m;
        for (int i = 0; i < qlen; i++) begin
            for (int j = 0; j < REF_LEN; j++) begin
                if (query_buf[i] > ref_buf[j]) c = query_buf[i] - ref_buf[j];
                else c = ref_buf[j] - query_buf[i];
                if (j == 0) begin
                    cur[0] = (i == 0) ? c : c + prev[0];
                end else if (i == 0) begin
                    cur[j] = c + cur[j-1];
                end else begin
                    m = (prev[j] < prev[j-1]) ? prev[j] : prev[j-1];
                    if (cur[j-1] < m) m = cur[j-1];
                    cur[j] = c + m;
                end
            end
            prev = cur;
        end
        return prev[REF_LEN-1];
    endfunction

    task automatic queue_query();
        logic [31:0] v;
        int          len;
        take_bits(3, v);
        len = 3 + int'(v);
        for (int i = 0; i < len; i++) begin
            take_bits(16, v);
            query_buf[i] = v[15:0];
            tx_q.push_back({i == len - 1, v[15:0]});
        end
        expected_sent += len;
        exp_q.push_back(dtw_model(len));
    endtask

    task automatic wait_results(input int n);
        int cnt;
        cnt = 0;
        while (got_q.size() < n && cnt < LIMIT) begin
            @(posedge S_AXI_clk);
            #1;
            cnt++;
        end
        if (got_q.size() < n) begin
            errors++;
            $display("Timed out waiting for result number %0d", n);
        end
    endtask

    // Every sample up to n has left the source FIFO
    task automatic wait_credits(input int n);
        int cnt;
        cnt = 0;
        while (credits_seen < n && cnt < LIMIT) begin
            @(posedge S_AXI_clk);
            #1;
            cnt++;
        end
        if (credits_seen < n) begin
            errors++;
            $display("Timed out waiting for %0d source credits", n);
        end
    endtask

    task automatic compare_results();
        while (checked < got_q.size()) begin
            if (checked < exp_q.size()) begin
                expect_equal("o_sink_data", got_q[checked], exp_q[checked]);
            end else begin
                errors++;
                $display("A result appeared that no query accounts for");
            end
            checked++;
        end
    endtask

    initial begin
        reg_data_t   rdata;
        logic        err;
        logic [31:0] v;
        int          idx;
        int          cnt;
        int          target;
        w_axi_rst     = 1'b1;
        i_reg_wr      = 1'b0;
        i_reg_rd      = 1'b0;
        i_reg_addr    = '0;
        i_reg_wdata   = '0;
        i_sink_credit = 1'b0;
        repeat (4) @(posedge S_AXI_clk);
        #1;
        w_axi_rst = 1'b0;

        // Identity, unknown index, status after reset
        reg_access(1'b0, `DTW_REG_VERSION, '0, rdata, err);
        expect_equal("o_reg_rdata", rdata, `DTW_VERSION);
        reg_access(1'b0, `DTW_REG_KEY, '0, rdata, err);
        expect_equal("o_reg_rdata", rdata, `DTW_KEY);
        reg_access(1'b0, 4'd12, '0, rdata, err);
        expect_equal("o_reg_err", err, 1);
        expect_equal("o_reg_rdata", rdata, 0);
        reg_access(1'b0, `DTW_REG_STATUS, '0, rdata, err);
        expect_equal("status", rdata, 32'h4);

        reg_access(1'b1, `DTW_REG_CONTROL, 32'h1, rdata, err);
        reg_access(1'b0, `DTW_REG_CONTROL, '0, rdata, err);
        expect_equal("control", rdata, 32'h1);
        reg_access(1'b1, `DTW_REG_REF_LEN, REF_LEN, rdata, err);
        reg_access(1'b0, `DTW_REG_REF_LEN, '0, rdata, err);
        expect_equal("ref_len", rdata, REF_LEN);

        // Reference load, then debug readout at random addresses
        reg_access(1'b1, `DTW_REG_CONTROL, 32'h2, rdata, err);
        for (int i = 0; i < REF_LEN; i++) begin
            take_bits(16, v);
            ref_buf[i] = v[15:0];
            tx_q.push_back({1'b0, v[15:0]});
        end
        expected_sent += REF_LEN;
        cnt   = 0;
        rdata = '0;
        while (!rdata[1] && cnt < 500) begin
            reg_access(1'b0, `DTW_REG_STATUS, '0, rdata, err);
            cnt++;
        end
        expect_equal("status load_done", rdata[1], 1);
        for (int k = 0; k < 8; k++) begin
            take_bits(5, v);
            idx = int'(v) % REF_LEN;
            reg_access(1'b1, `DTW_REG_REF_ADDR, idx, rdata, err);
            reg_access(1'b0, `DTW_REG_REF_DOUT, '0, rdata, err);
            expect_equal("o_reg_rdata", rdata, {16'd0, ref_buf[idx]});
        end

        // Queries with sink slots granted up front
        reg_access(1'b1, `DTW_REG_CONTROL, 32'h6, rdata, err);
        repeat (6) grant_credit();
        repeat (6) queue_query();
        wait_results(6);
        compare_results();
        reg_access(1'b0, `DTW_REG_NQUERY, '0, rdata, err);
        expect_equal("nquery", rdata, 6);

        // No slots held, so the engine parks in its emit state
        queue_query();
        target = expected_sent;
        queue_query();
        wait_credits(target);
        repeat (200) @(posedge S_AXI_clk);
        #1;
        expect_equal("sink result count", got_q.size(), 6);
        for (int k = 0; k < 2; k++) begin
            grant_credit();
            wait_results(7 + k);
            wait_credits(expected_sent);
            repeat (200) @(posedge S_AXI_clk);
            #1;
            expect_equal("sink result count", got_q.size(), 7 + k);
        end
        compare_results();

        // Engine idle and source FIFO empty
        cnt   = 0;
        rdata = '0;
        while ((!rdata[2] || rdata[0]) && cnt < 500) begin
            reg_access(1'b0, `DTW_REG_STATUS, '0, rdata, err);
            cnt++;
        end
        if (!rdata[2] || rdata[0]) begin
            errors++;
            $display("Engine and source FIFO did not go idle before the timeout");
        end
        expect_equal("o_src_credit pulses", credits_seen, sent);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/dtw_accel.sv
`timescale 1ns/1ps

module dtw_accel import dtw_pkg::*; (
    input  logic      S_AXI_clk,
    input  logic      w_axi_rst,
    input  logic      i_reg_wr,
    input  logic      i_reg_rd,
    input  reg_addr_t i_reg_addr,
    input  reg_data_t i_reg_wdata,
    output reg_data_t o_reg_rdata,
    output logic      o_reg_ack,
    output logic      o_reg_err,
    input  logic      i_src_valid,
    input  sample_t   i_src_data,
    input  logic      i_src_last,
    output logic      o_src_credit,
    output logic      o_sink_valid,
    output dist_t     o_sink_data,
    input  logic      i_sink_credit
);
    logic       clear, run, mode;
    logic [8:0] ref_len;
    logic       core_busy, load_done, load_busy, query_done;
    logic       fifo_empty, fifo_full, fifo_last, ld_pop, core_pop;
    sample_t    fifo_data, ld_data, rdata;
    logic       ld_req, ld_gnt, core_req, core_gnt, dbg_req, dbg_gnt;
    logic       core_rvalid, dbg_rvalid;
    ref_addr_t  ld_addr, core_addr, dbg_addr;

    dtw_reg_file u_regs (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst),
        .i_reg_wr(i_reg_wr), .i_reg_rd(i_reg_rd), .i_reg_addr(i_reg_addr),
        .i_reg_wdata(i_reg_wdata), .i_core_busy(core_busy), .i_load_done(load_done),
        .i_load_busy(load_busy), .i_fifo_empty(fifo_empty), .i_fifo_full(fifo_full),
        .i_query_done(query_done), .i_dbg_gnt(dbg_gnt), .i_dbg_rvalid(dbg_rvalid),
        .i_dbg_rdata(rdata), .o_reg_rdata(o_reg_rdata), .o_reg_ack(o_reg_ack),
        .o_reg_err(o_reg_err), .o_clear(clear), .o_run(run), .o_mode(mode),
        .o_ref_len(ref_len), .o_dbg_req(dbg_req), .o_dbg_addr(dbg_addr)
    );

    // Only the block of the selected mode pops
    dtw_src_fifo u_src_fifo (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst), .i_clear(clear),
        .i_push(i_src_valid), .i_push_data(i_src_data), .i_push_last(i_src_last),
        .i_pop(ld_pop | core_pop), .o_data(fifo_data), .o_last(fifo_last),
        .o_empty(fifo_empty), .o_full(fifo_full), .o_credit(o_src_credit)
    );

    dtw_ref_mem u_ref_mem (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst),
        .i_ld_req(ld_req), .i_ld_addr(ld_addr), .i_ld_data(ld_data),
        .i_core_req(core_req), .i_core_addr(core_addr),
        .i_dbg_req(dbg_req), .i_dbg_addr(dbg_addr),
        .o_ld_gnt(ld_gnt), .o_core_gnt(core_gnt), .o_dbg_gnt(dbg_gnt),
        .o_core_rvalid(core_rvalid), .o_dbg_rvalid(dbg_rvalid), .o_rdata(rdata)
    );

    dtw_ref_loader u_loader (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst), .i_clear(clear),
        .i_run(run), .i_mode(mode), .i_ref_len(ref_len),
        .i_fifo_empty(fifo_empty), .i_fifo_data(fifo_data), .i_ld_gnt(ld_gnt),
        .o_fifo_pop(ld_pop), .o_ld_req(ld_req), .o_ld_addr(ld_addr),
        .o_ld_data(ld_data), .o_busy(load_busy), .o_load_done(load_done)
    );

    dtw_core u_core (
        .S_AXI_clk(S_AXI_clk), .w_axi_rst(w_axi_rst), .i_clear(clear),
        .i_run(run), .i_mode(mode), .i_ref_len(ref_len),
        .i_fifo_empty(fifo_empty), .i_fifo_data(fifo_data), .i_fifo_last(fifo_last),
        .i_core_gnt(core_gnt), .i_core_rvalid(core_rvalid), .i_rdata(rdata),
        .i_sink_credit(i_sink_credit), .o_fifo_pop(core_pop), .o_core_req(core_req),
        .o_core_addr(core_addr), .o_busy(core_busy), .o_query_done(query_done),
        .o_sink_valid(o_sink_valid), .o_sink_data(o_sink_data)
    );

endmodule

//--- verilog/dtw_core.sv
`timescale 1ns/1ps
`include "dtw_defs.svh"

module dtw_core import dtw_pkg::*; (
    input  logic       S_AXI_clk,
    input  logic       w_axi_rst,
    input  logic       i_clear,
    input  logic       i_run,
    input  logic       i_mode,
    input  logic [8:0] i_ref_len,
    input  logic       i_fifo_empty,
    input  sample_t    i_fifo_data,
    input  logic       i_fifo_last,
    input  logic       i_core_gnt,
    input  logic       i_core_rvalid,
    input  sample_t    i_rdata,
    input  logic       i_sink_credit,
    output logic       o_fifo_pop,
    output logic       o_core_req,
    output ref_addr_t  o_core_addr,
    output logic       o_busy,
    output logic       o_query_done,
    output logic       o_sink_valid,
    output dist_t      o_sink_data
);
    core_state_t state;
    dist_t       row [`DTW_MAX_REF];
    ref_addr_t   j;
    logic        first_row;
    logic        q_last;
    sample_t     q;
    sample_t     diff;
    dist_t       c, prev_d, left_d, old_d, best, new_d, result;
    logic [15:0] credits;
    logic        start, row_end, emit;

    assign start        = (state == C_IDLE) && i_run && i_mode && !i_clear && !i_fifo_empty;
    assign row_end      = ({1'b0, j} == i_ref_len - 9'd1);
    assign emit         = (state == C_EMIT) && (credits != '0);
    assign diff         = (q > i_rdata) ? q - i_rdata : i_rdata - q;
    assign o_fifo_pop   = start;
    assign o_core_req   = (state == C_FETCH);
    assign o_core_addr  = j;
    assign o_busy       = (state != C_IDLE);
    assign o_query_done = emit;
    assign o_sink_valid = emit;
    assign o_sink_data  = result;

    // prev_d is the old D[j-1], left_d the new D[j-1]
    always_comb begin
        old_d = row[j];
        best  = (old_d < prev_d) ? old_d : prev_d;
        if (left_d < best) best = left_d;
        if (j == '0) new_d = first_row ? c : c + old_d;
        else         new_d = first_row ? c + left_d : c + best;
    end

    always_ff @(posedge S_AXI_clk) begin
        if (start) begin
            q      <= i_fifo_data;
            q_last <= i_fifo_last;
        end
        if (state == C_WAIT && i_core_rvalid) c <= {16'd0, diff};
        if (state == C_UPDATE) begin
            row[j] <= new_d;
            prev_d <= old_d;
            left_d <= new_d;
            if (row_end) result <= new_d;
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_clear) begin
            state     <= C_IDLE;
            j         <= '0;
            first_row <= 1'b1;
        end else begin
            case (state)
                C_IDLE: begin
                    if (start) begin
                        j     <= '0;
                        state <= C_FETCH;
                    end
                end
                C_FETCH:  if (i_core_gnt) state <= C_WAIT;
                C_WAIT:   if (i_core_rvalid) state <= C_UPDATE;
                C_UPDATE: begin
                    if (row_end) begin
                        // A last-flagged sample closes the query
                        first_row <= q_last;
                        state     <= q_last ? C_EMIT : C_IDLE;
                    end else begin
                        j     <= j + 1'b1;
                        state <= C_FETCH;
                    end
                end
                C_EMIT:   if (emit) state <= C_IDLE;
                default:  state <= C_IDLE;
            endcase
        end
    end

    // Sink slots granted and not yet used
    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            credits <= '0;
        end else if (i_sink_credit && !emit) begin
            credits <= credits + 1'b1;
        end else if (!i_sink_credit && emit) begin
            credits <= credits - 1'b1;
        end
    end

endmodule

//--- verilog/dtw_defs.svh
`ifndef DTW_DEFS_SVH
`define DTW_DEFS_SVH

// Register indices
`define DTW_REG_CONTROL   4'd0
`define DTW_REG_STATUS    4'd1
`define DTW_REG_REF_LEN   4'd2
`define DTW_REG_VERSION   4'd3
`define DTW_REG_KEY       4'd4
`define DTW_REG_REF_ADDR  4'd5
`define DTW_REG_REF_DOUT  4'd6
`define DTW_REG_NQUERY    4'd7

// Control register bits, mode 0 is load and 1 is query
`define DTW_CTRL_CLEAR    0
`define DTW_CTRL_RUN      1
`define DTW_CTRL_MODE     2

`define DTW_VERSION       32'h0100_0000
`define DTW_KEY           32'h0CA7_CAFE

`define DTW_SRC_DEPTH     4
`define DTW_MAX_REF       256

`endif

//--- verilog/dtw_pkg.sv
package dtw_pkg;

    typedef logic [15:0] sample_t;
    typedef logic [31:0] dist_t;
    typedef logic [7:0]  ref_addr_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Engine walks one reference sample per fetch/wait/update round
    typedef enum logic [2:0] {
        C_IDLE, C_FETCH, C_WAIT, C_UPDATE, C_EMIT
    } core_state_t;

    typedef enum logic [1:0] {
        L_IDLE, L_COPY, L_DONE
    } load_state_t;

endpackage

//--- verilog/dtw_ref_loader.sv
`timescale 1ns/1ps

module dtw_ref_loader import dtw_pkg::*; (
    input  logic       S_AXI_clk,
    input  logic       w_axi_rst,
    input  logic       i_clear,
    input  logic       i_run,
    input  logic       i_mode,
    input  logic [8:0] i_ref_len,
    input  logic       i_fifo_empty,
    input  sample_t    i_fifo_data,
    input  logic       i_ld_gnt,
    output logic       o_fifo_pop,
    output logic       o_ld_req,
    output ref_addr_t  o_ld_addr,
    output sample_t    o_ld_data,
    output logic       o_busy,
    output logic       o_load_done
);
    load_state_t state;
    logic [8:0]  addr;
    logic        have;

    // Only pop while samples are still owed to the memory
    assign o_fifo_pop  = (state == L_COPY) && !have && !i_fifo_empty && (addr != i_ref_len);
    assign o_ld_req    = have;
    assign o_ld_addr   = addr[7:0];
    assign o_busy      = (state == L_COPY);
    assign o_load_done = (state == L_DONE);

    always_ff @(posedge S_AXI_clk) begin
        if (o_fifo_pop) begin
            o_ld_data <= i_fifo_data;
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst || i_clear) begin
            state <= L_IDLE;
            addr  <= '0;
            have  <= 1'b0;
        end else begin
            case (state)
                L_IDLE: begin
                    if (i_run && !i_mode) begin
                        addr  <= '0;
                        state <= L_COPY;
                    end
                end
                L_COPY: begin
                    if (o_fifo_pop) begin
                        have <= 1'b1;
                    end else if (have && i_ld_gnt) begin
                        have <= 1'b0;
                        addr <= addr + 1'b1;
                    end else if (!have && addr == i_ref_len) begin
                        state <= L_DONE;
                    end
                end
                // Held until clear
                L_DONE: ;
                default: state <= L_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/dtw_ref_mem.sv
`timescale 1ns/1ps
`include "dtw_defs.svh"

module dtw_ref_mem import dtw_pkg::*; (
    input  logic      S_AXI_clk,
    input  logic      w_axi_rst,
    input  logic      i_ld_req,
    input  ref_addr_t i_ld_addr,
    input  sample_t   i_ld_data,
    input  logic      i_core_req,
    input  ref_addr_t i_core_addr,
    input  logic      i_dbg_req,
    input  ref_addr_t i_dbg_addr,
    output logic      o_ld_gnt,
    output logic      o_core_gnt,
    output logic      o_dbg_gnt,
    output logic      o_core_rvalid,
    output logic      o_dbg_rvalid,
    output sample_t   o_rdata
);
    sample_t   mem [`DTW_MAX_REF];
    ref_addr_t rd_addr;

    // Fixed priority: loader, then engine, then debug
    assign o_ld_gnt   = i_ld_req;
    assign o_core_gnt = i_core_req && !i_ld_req;
    assign o_dbg_gnt  = i_dbg_req && !i_ld_req && !i_core_req;
    assign rd_addr    = o_core_gnt ? i_core_addr : i_dbg_addr;

    always_ff @(posedge S_AXI_clk) begin
        if (o_ld_gnt) begin
            mem[i_ld_addr] <= i_ld_data;
        end
        o_rdata <= mem[rd_addr];
    end

    // Read data is tagged for the port that won the cycle
    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            o_core_rvalid <= 1'b0;
            o_dbg_rvalid  <= 1'b0;
        end else begin
            o_core_rvalid <= o_core_gnt;
            o_dbg_rvalid  <= o_dbg_gnt;
        end
    end

endmodule

//--- verilog/dtw_reg_file.sv
`timescale 1ns/1ps
`include "dtw_defs.svh"

module dtw_reg_file import dtw_pkg::*; (
    input  logic       S_AXI_clk,
    input  logic       w_axi_rst,
    input  logic       i_reg_wr,
    input  logic       i_reg_rd,
    input  reg_addr_t  i_reg_addr,
    input  reg_data_t  i_reg_wdata,
    input  logic       i_core_busy,
    input  logic       i_load_done,
    input  logic       i_load_busy,
    input  logic       i_fifo_empty,
    input  logic       i_fifo_full,
    input  logic       i_query_done,
    input  logic       i_dbg_gnt,
    input  logic       i_dbg_rvalid,
    input  sample_t    i_dbg_rdata,
    output reg_data_t  o_reg_rdata,
    output logic       o_reg_ack,
    output logic       o_reg_err,
    output logic       o_clear,
    output logic       o_run,
    output logic       o_mode,
    output logic [8:0] o_ref_len,
    output logic       o_dbg_req,
    output ref_addr_t  o_dbg_addr
);
    logic [2:0] ctrl;
    ref_addr_t  ref_addr;
    reg_data_t  nquery;
    reg_data_t  status;

    assign o_clear    = ctrl[`DTW_CTRL_CLEAR];
    assign o_run      = ctrl[`DTW_CTRL_RUN];
    assign o_mode     = ctrl[`DTW_CTRL_MODE];
    assign o_dbg_addr = ref_addr;
    assign status     = {27'd0, i_load_busy, i_fifo_full, i_fifo_empty, i_load_done, i_core_busy};

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            ctrl        <= '0;
            o_ref_len   <= '0;
            ref_addr    <= '0;
            nquery      <= '0;
            o_reg_rdata <= '0;
            o_reg_ack   <= 1'b0;
            o_reg_err   <= 1'b0;
            o_dbg_req   <= 1'b0;
        end else begin
            o_reg_ack <= 1'b0;
            o_reg_err <= 1'b0;
            if (o_clear) begin
                nquery <= '0;
            end else if (i_query_done) begin
                nquery <= nquery + 1'b1;
            end
            if (i_reg_wr) begin
                o_reg_ack   <= 1'b1;
                o_reg_rdata <= '0;
                case (i_reg_addr)
                    `DTW_REG_CONTROL:  ctrl      <= i_reg_wdata[2:0];
                    `DTW_REG_REF_LEN:  o_ref_len <= i_reg_wdata[8:0];
                    `DTW_REG_REF_ADDR: ref_addr  <= i_reg_wdata[7:0];
                    `DTW_REG_STATUS, `DTW_REG_VERSION, `DTW_REG_KEY,
                    `DTW_REG_REF_DOUT, `DTW_REG_NQUERY: ;
                    default: o_reg_err <= 1'b1;
                endcase
            end else if (i_reg_rd) begin
                // Memory readout completes later through the arbiter
                if (i_reg_addr == `DTW_REG_REF_DOUT) begin
                    o_dbg_req <= 1'b1;
                end else begin
                    o_reg_ack <= 1'b1;
                    case (i_reg_addr)
                        `DTW_REG_CONTROL:  o_reg_rdata <= {29'd0, ctrl};
                        `DTW_REG_STATUS:   o_reg_rdata <= status;
                        `DTW_REG_REF_LEN:  o_reg_rdata <= {23'd0, o_ref_len};
                        `DTW_REG_VERSION:  o_reg_rdata <= `DTW_VERSION;
                        `DTW_REG_KEY:      o_reg_rdata <= `DTW_KEY;
                        `DTW_REG_REF_ADDR: o_reg_rdata <= {24'd0, ref_addr};
                        `DTW_REG_NQUERY:   o_reg_rdata <= nquery;
                        default: begin
                            o_reg_rdata <= '0;
                            o_reg_err   <= 1'b1;
                        end
                    endcase
                end
            end
            if (o_dbg_req && i_dbg_gnt) begin
                o_dbg_req <= 1'b0;
            end
            if (i_dbg_rvalid) begin
                o_reg_ack   <= 1'b1;
                o_reg_rdata <= {16'd0, i_dbg_rdata};
            end
        end
    end

endmodule

//--- verilog/dtw_src_fifo.sv
`timescale 1ns/1ps
`include "dtw_defs.svh"

module dtw_src_fifo import dtw_pkg::*; #(
    parameter int DEPTH = `DTW_SRC_DEPTH
) (
    input  logic    S_AXI_clk,
    input  logic    w_axi_rst,
    input  logic    i_clear,
    input  logic    i_push,
    input  sample_t i_push_data,
    input  logic    i_push_last,
    input  logic    i_pop,
    output sample_t o_data,
    output logic    o_last,
    output logic    o_empty,
    output logic    o_full,
    output logic    o_credit
);
    localparam int AW = $clog2(DEPTH);

    sample_t     mem_data [DEPTH];
    logic        mem_last [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    // Extra pointer bit tells full from empty
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_data  = mem_data[rd_ptr[AW-1:0]];
    assign o_last  = mem_last[rd_ptr[AW-1:0]];

    always_ff @(posedge S_AXI_clk) begin
        if (i_push && !o_full) begin
            mem_data[wr_ptr[AW-1:0]] <= i_push_data;
            mem_last[wr_ptr[AW-1:0]] <= i_push_last;
        end
    end

    always_ff @(posedge S_AXI_clk) begin
        if (w_axi_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            o_credit <= 1'b0;
        end else begin
            // One credit back to the sender per freed slot
            o_credit <= i_pop && !o_empty;
            if (i_clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (i_push && !o_full) wr_ptr <= wr_ptr + 1'b1;
                if (i_pop && !o_empty) rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule
